// ==== source/rv_pkg.sv ====
package rv_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      reg_idx_t;
   typedef logic [2:0]      funct3_t;
   typedef logic [6:0]      funct7_t;

   // Major opcodes, bits [6:0] of the instruction
   typedef enum logic [6:0] {
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_BRANCH = 7'b1100011,
      OPC_IMM    = 7'b0010011,
      OPC_REG    = 7'b0110011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_PASS_B
   } alu_op_e;

   // Same codes as funct3 of the branch instructions
   typedef enum logic [2:0] {
      BR_EQ  = 3'b000,
      BR_NE  = 3'b001,
      BR_LT  = 3'b100,
      BR_GE  = 3'b101,
      BR_LTU = 3'b110,
      BR_GEU = 3'b111
   } branch_e;

   typedef enum logic [2:0] {
      KIND_ALU,
      KIND_AUIPC,
      KIND_BRANCH,
      KIND_JAL,
      KIND_JALR,
      KIND_NOP
   } kind_e;

endpackage

// ==== source/rv_stage_if.sv ====
`timescale 1ns/100ps

// Decoded instruction and operands from decode to execute
interface dec_if import rv_pkg::*; ();

   logic     valid;
   kind_e    kind;
   alu_op_e  alu_op;
   branch_e  branch;
   reg_idx_t rd;
   logic     wr_en;
   word_t    op_a;
   word_t    op_b;
   word_t    imm;
   word_t    pc;

   modport source (
      output valid, kind, alu_op, branch, rd, wr_en, op_a, op_b, imm, pc
   );

   modport sink (
      input valid, kind, alu_op, branch, rd, wr_en, op_a, op_b, imm, pc
   );

endinterface

// Computed result from execute to write-back
interface res_if import rv_pkg::*; ();

   logic     valid;
   reg_idx_t rd;
   logic     wr_en;
   word_t    result;
   logic     pc_change;
   word_t    new_pc;

   modport source (output valid, rd, wr_en, result, pc_change, new_pc);

   modport sink (input valid, rd, wr_en, result, pc_change, new_pc);

endinterface

// ==== source/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode import rv_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_req,
   input  word_t    i_inst,
   input  word_t    i_pc,
   input  logic     i_wb_done,
   input  word_t    i_rs1_data,
   input  word_t    i_rs2_data,
   output logic     o_ack,
   output reg_idx_t o_rs1_idx,
   output reg_idx_t o_rs2_idx,
   dec_if.source    o_dec
);

   typedef enum logic [1:0] {IDLE, WAIT_DONE, ACK} state_e;

   state_e   state;
   opcode_e  opcode;
   funct3_t  funct3;
   funct7_t  funct7;
   reg_idx_t rd;
   word_t    imm_i;
   word_t    imm_u;
   word_t    imm_b;
   word_t    imm_j;
   kind_e    kind;
   alu_op_e  alu_op;
   word_t    imm;
   logic     use_imm;
   logic     wr_en;
   logic     accept;

   // funct7[5] selects SUB only for register ops and SRA for both
   function automatic alu_op_e alu_from_funct3(input funct3_t f3, input logic alt,
                                               input logic is_reg);
      alu_op_e op;
      case (f3)
         3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
         3'b001:  op = ALU_SLL;
         3'b010:  op = ALU_SLT;
         3'b011:  op = ALU_SLTU;
         3'b100:  op = ALU_XOR;
         3'b101:  op = alt ? ALU_SRA : ALU_SRL;
         3'b110:  op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   assign opcode    = opcode_e'(i_inst[6:0]);
   assign rd        = i_inst[11:7];
   assign funct3    = i_inst[14:12];
   assign o_rs1_idx = i_inst[19:15];
   assign o_rs2_idx = i_inst[24:20];
   assign funct7    = i_inst[31:25];

   assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
   assign imm_u = {i_inst[31:12], 12'b0};
   assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
   assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21],
                   1'b0};

   always_comb begin
      kind    = KIND_NOP;
      alu_op  = ALU_ADD;
      imm     = imm_i;
      use_imm = 1'b1;
      wr_en   = 1'b0;
      case (opcode)
         OPC_LUI: begin
            kind   = KIND_ALU;
            alu_op = ALU_PASS_B;
            imm    = imm_u;
            wr_en  = 1'b1;
         end
         OPC_AUIPC: begin
            kind  = KIND_AUIPC;
            imm   = imm_u;
            wr_en = 1'b1;
         end
         OPC_JAL: begin
            kind  = KIND_JAL;
            imm   = imm_j;
            wr_en = 1'b1;
         end
         OPC_JALR: begin
            kind  = KIND_JALR;
            wr_en = 1'b1;
         end
         OPC_BRANCH: begin
            kind    = KIND_BRANCH;
            imm     = imm_b;
            use_imm = 1'b0;
         end
         OPC_IMM: begin
            kind   = KIND_ALU;
            alu_op = alu_from_funct3(funct3, funct7[5], 1'b0);
            wr_en  = 1'b1;
         end
         OPC_REG: begin
            kind    = KIND_ALU;
            alu_op  = alu_from_funct3(funct3, funct7[5], 1'b1);
            use_imm = 1'b0;
            wr_en   = 1'b1;
         end
         OPC_LOAD, OPC_STORE: kind = KIND_NOP;
         default: kind = KIND_NOP;
      endcase
      // x0 destination never writes
      if (rd == '0) begin
         wr_en = 1'b0;
      end
   end

   assign accept = (state == IDLE) && i_req;
   assign o_ack  = (state == ACK);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state       <= IDLE;
         o_dec.valid <= 1'b0;
      end else begin
         o_dec.valid <= accept;
         case (state)
            IDLE:      if (i_req) state <= WAIT_DONE;
            WAIT_DONE: if (i_wb_done) state <= ACK;
            ACK:       if (!i_req) state <= IDLE;
            default:   state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         o_dec.kind   <= kind;
         o_dec.alu_op <= alu_op;
         o_dec.branch <= branch_e'(funct3);
         o_dec.rd     <= rd;
         o_dec.wr_en  <= wr_en;
         o_dec.op_a   <= i_rs1_data;
         o_dec.op_b   <= use_imm ? imm : i_rs2_data;
         o_dec.imm    <= imm;
         o_dec.pc     <= i_pc;
      end
   end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; #(
   parameter int NUM_REGS = 32
) (
   input  logic     clk,
   input  logic     i_rst_n,
   input  reg_idx_t i_rs1_idx,
   input  reg_idx_t i_rs2_idx,
   input  logic     i_wr_en,
   input  reg_idx_t i_wr_idx,
   input  word_t    i_wr_data,
   output word_t    o_rs1_data,
   output word_t    o_rs2_data,
   output word_t    o_regs [NUM_REGS]
);

   localparam int IDX_W = $clog2(NUM_REGS);

   word_t regs [NUM_REGS];

   // Entry 0 is cleared by reset and never written
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en && i_wr_idx != '0 && i_wr_idx < NUM_REGS) begin
         regs[i_wr_idx[IDX_W-1:0]] <= i_wr_data;
      end
   end

   // Indices past an RV32E file read as zero
   assign o_rs1_data = (i_rs1_idx < NUM_REGS) ? regs[i_rs1_idx[IDX_W-1:0]] : '0;
   assign o_rs2_data = (i_rs2_idx < NUM_REGS) ? regs[i_rs2_idx[IDX_W-1:0]] : '0;
   assign o_regs     = regs;

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/100ps

module rv_execute import rv_pkg::*; (
   input logic   clk,
   input logic   i_rst_n,
   dec_if.sink   i_dec,
   res_if.source o_res
);

   logic [4:0] shamt;
   logic       eq;
   logic       lt_s;
   logic       lt_u;
   logic       taken;
   word_t      alu_out;
   word_t      pc_plus_imm;
   word_t      link;
   word_t      jalr_target;
   word_t      result;
   logic       pc_change;
   word_t      new_pc;

   assign shamt = i_dec.op_b[4:0];
   assign eq    = (i_dec.op_a == i_dec.op_b);
   assign lt_s  = ($signed(i_dec.op_a) < $signed(i_dec.op_b));
   assign lt_u  = (i_dec.op_a < i_dec.op_b);

   always_comb begin
      case (i_dec.alu_op)
         ALU_ADD:    alu_out = i_dec.op_a + i_dec.op_b;
         ALU_SUB:    alu_out = i_dec.op_a - i_dec.op_b;
         ALU_SLL:    alu_out = i_dec.op_a << shamt;
         ALU_SLT:    alu_out = word_t'(lt_s);
         ALU_SLTU:   alu_out = word_t'(lt_u);
         ALU_XOR:    alu_out = i_dec.op_a ^ i_dec.op_b;
         ALU_SRL:    alu_out = i_dec.op_a >> shamt;
         ALU_SRA:    alu_out = word_t'($signed(i_dec.op_a) >>> shamt);
         ALU_OR:     alu_out = i_dec.op_a | i_dec.op_b;
         ALU_AND:    alu_out = i_dec.op_a & i_dec.op_b;
         ALU_PASS_B: alu_out = i_dec.op_b;
         default:    alu_out = '0;
      endcase
   end

   always_comb begin
      case (i_dec.branch)
         BR_EQ:   taken = eq;
         BR_NE:   taken = !eq;
         BR_LT:   taken = lt_s;
         BR_GE:   taken = !lt_s;
         BR_LTU:  taken = lt_u;
         BR_GEU:  taken = !lt_u;
         default: taken = 1'b0;
      endcase
   end

   assign pc_plus_imm = i_dec.pc + i_dec.imm;
   assign link        = i_dec.pc + 32'd4;
   assign jalr_target = (i_dec.op_a + i_dec.imm) & ~word_t'(1);

   // Without a PC change the reported target is the next sequential PC
   always_comb begin
      result    = alu_out;
      pc_change = 1'b0;
      new_pc    = link;
      case (i_dec.kind)
         KIND_AUIPC: result = pc_plus_imm;
         KIND_BRANCH: begin
            pc_change = taken;
            if (taken) begin
               new_pc = pc_plus_imm;
            end
         end
         KIND_JAL: begin
            result    = link;
            pc_change = 1'b1;
            new_pc    = pc_plus_imm;
         end
         KIND_JALR: begin
            result    = link;
            pc_change = 1'b1;
            new_pc    = jalr_target;
         end
         default: result = alu_out;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_res.valid <= 1'b0;
      end else begin
         o_res.valid <= i_dec.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (i_dec.valid) begin
         o_res.rd        <= i_dec.rd;
         o_res.wr_en     <= i_dec.wr_en;
         o_res.result    <= result;
         o_res.pc_change <= pc_change;
         o_res.new_pc    <= new_pc;
      end
   end

endmodule

// ==== source/rv_result.sv ====
`timescale 1ns/100ps

module rv_result import rv_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   res_if.sink      i_res,
   output logic     o_wr_en,
   output reg_idx_t o_wr_idx,
   output word_t    o_wr_data,
   output logic     o_pc_change,
   output word_t    o_new_pc,
   output logic     o_wb_done
);

   // Register file takes the write on the same edge the PC outputs update
   assign o_wr_en   = i_res.valid && i_res.wr_en;
   assign o_wr_idx  = i_res.rd;
   assign o_wr_data = i_res.result;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_pc_change <= 1'b0;
         o_new_pc    <= '0;
         o_wb_done   <= 1'b0;
      end else begin
         o_wb_done <= i_res.valid;
         // Held until the next instruction completes
         if (i_res.valid) begin
            o_pc_change <= i_res.pc_change;
            o_new_pc    <= i_res.new_pc;
         end
      end
   end

endmodule

// ==== source/rv_exec_top.sv ====
`timescale 1ns/100ps

module rv_exec_top import rv_pkg::*; #(
   parameter int NUM_REGS = 32
) (
   input  logic  clk,
   input  logic  i_rst_n,
   input  logic  i_req,
   output logic  o_ack,
   input  word_t i_inst,
   input  word_t i_pc,
   output logic  o_pc_change,
   output word_t o_new_pc,
   output word_t o_regs [NUM_REGS]
);

   reg_idx_t rs1_idx;
   reg_idx_t rs2_idx;
   word_t    rs1_data;
   word_t    rs2_data;
   logic     wr_en;
   reg_idx_t wr_idx;
   word_t    wr_data;
   logic     wb_done;

   dec_if dec_bus ();
   res_if res_bus ();

   rv_decode rv_decode_inst (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_req      (i_req),
      .i_inst     (i_inst),
      .i_pc       (i_pc),
      .i_wb_done  (wb_done),
      .i_rs1_data (rs1_data),
      .i_rs2_data (rs2_data),
      .o_ack      (o_ack),
      .o_rs1_idx  (rs1_idx),
      .o_rs2_idx  (rs2_idx),
      .o_dec      (dec_bus.source)
   );

   rv_regfile #(
      .NUM_REGS (NUM_REGS)
   ) rv_regfile_inst (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rs1_idx  (rs1_idx),
      .i_rs2_idx  (rs2_idx),
      .i_wr_en    (wr_en),
      .i_wr_idx   (wr_idx),
      .i_wr_data  (wr_data),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data),
      .o_regs     (o_regs)
   );

   rv_execute rv_execute_inst (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_dec   (dec_bus.sink),
      .o_res   (res_bus.source)
   );

   rv_result rv_result_inst (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_res       (res_bus.sink),
      .o_wr_en     (wr_en),
      .o_wr_idx    (wr_idx),
      .o_wr_data   (wr_data),
      .o_pc_change (o_pc_change),
      .o_new_pc    (o_new_pc),
      .o_wb_done   (wb_done)
   );

endmodule

// ==== dv/rv_exec_tb.sv ====
`timescale 1ns/100ps

module rv_exec_tb import rv_pkg::*; ();

   localparam int NUM_REGS   = 32;
   // Upper bound on instructions issued by all tests together
   localparam int MAX_ISSUES = 200;

   logic  clk;
   logic  i_rst_n;
   logic  i_req;
   logic  o_ack;
   word_t i_inst;
   word_t i_pc;
   logic  o_pc_change;
   word_t o_new_pc;
   word_t regs [NUM_REGS];
   word_t snap [NUM_REGS];

   rv_exec_top #(
      .NUM_REGS (NUM_REGS)
   ) rv_exec_top_inst (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_req       (i_req),
      .o_ack       (o_ack),
      .i_inst      (i_inst),
      .i_pc        (i_pc),
      .o_pc_change (o_pc_change),
      .o_new_pc    (o_new_pc),
      .o_regs      (regs)
   );

   always #50 clk = ~clk;

   // Instruction encoders
   function automatic funct3_t funct3_of(input alu_op_e op);
      case (op)
         ALU_SLL:          return 3'b001;
         ALU_SLT:          return 3'b010;
         ALU_SLTU:         return 3'b011;
         ALU_XOR:          return 3'b100;
         ALU_SRL, ALU_SRA: return 3'b101;
         ALU_OR:           return 3'b110;
         ALU_AND:          return 3'b111;
         default:          return 3'b000;
      endcase
   endfunction

   function automatic funct7_t funct7_of(input alu_op_e op);
      return (op == ALU_SUB || op == ALU_SRA) ? 7'h20 : 7'h00;
   endfunction

   function automatic word_t enc_r(input alu_op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                                   input reg_idx_t rs2);
      return {funct7_of(op), rs2, rs1, funct3_of(op), rd, OPC_REG};
   endfunction

   function automatic word_t enc_i(input opcode_e opc, input funct3_t f3, input reg_idx_t rd,
                                   input reg_idx_t rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t enc_u(input opcode_e opc, input reg_idx_t rd,
                                   input logic [19:0] upper);
      return {upper, rd, opc};
   endfunction

   function automatic word_t enc_j(input reg_idx_t rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
   endfunction

   function automatic word_t enc_b(input branch_e br, input reg_idx_t rs1, input reg_idx_t rs2,
                                   input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, br, off[4:1], off[11], OPC_BRANCH};
   endfunction

   function automatic word_t sext12(input logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   // RV32I reference results
   function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
      logic [4:0] sh;
      word_t      fill;
      sh   = b[4:0];
      fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0;
      case (op)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_SLL:  return a << sh;
         ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
         ALU_SLTU: return {31'b0, a < b};
         ALU_XOR:  return a ^ b;
         ALU_SRL:  return a >> sh;
         ALU_SRA:  return (a >> sh) | fill;
         ALU_OR:   return a | b;
         ALU_AND:  return a & b;
         default:  return b;
      endcase
   endfunction

   function automatic logic branch_ref(input branch_e br, input word_t a, input word_t b);
      logic lt_s;
      lt_s = (a[31] != b[31]) ? a[31] : (a < b);
      case (br)
         BR_EQ:   return a == b;
         BR_NE:   return a != b;
         BR_LT:   return lt_s;
         BR_GE:   return !lt_s;
         BR_LTU:  return a < b;
         BR_GEU:  return !(a < b);
         default: return 1'b0;
      endcase
   endfunction

   task automatic stop_with_failure();
      $display("** FAIL **");
      $fatal(1, "Simulation stopped at the first failing check");
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR @ %0t: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("ERROR @ %0t: %s: got %b, expected %b", $time, what, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_unchanged(input string what);
      for (int i = 0; i < NUM_REGS; i++) begin
         check_word(regs[i], snap[i], $sformatf("%s x%0d", what, i));
      end
   endtask

   // Four-phase handshake pieces driven on falling edges
   task automatic raise_req(input word_t inst, input word_t pc);
      @(negedge clk);
      i_inst = inst;
      i_pc   = pc;
      i_req  = 1'b1;
   endtask

   task automatic wait_ack();
      @(negedge clk);
      while (!o_ack) @(negedge clk);
   endtask

   task automatic drop_req();
      i_req = 1'b0;
      @(negedge clk);
      while (o_ack) @(negedge clk);
   endtask

   task automatic issue(input word_t inst, input word_t pc);
      raise_req(inst, pc);
      wait_ack();
      drop_req();
   endtask

   // LUI then ADDI with the upper part rounded up for a negative low part
   task automatic set_reg(input reg_idx_t rd, input word_t val);
      logic [19:0] upper;
      upper = val[31:12] + {19'b0, val[11]};
      issue(enc_u(OPC_LUI, rd, upper), 32'h0);
      issue(enc_i(OPC_IMM, 3'b000, rd, rd, val[11:0]), 32'h0);
      check_word(regs[rd], val, $sformatf("LUI/ADDI load of x%0d", rd));
   endtask

   task automatic run_imm(input alu_op_e op, input word_t a, input logic [11:0] imm);
      logic [11:0] field;
      word_t       exp;
      field = (op inside {ALU_SLL, ALU_SRL, ALU_SRA}) ? {funct7_of(op), imm[4:0]} : imm;
      exp   = alu_ref(op, a, sext12(field));
      issue(enc_i(OPC_IMM, funct3_of(op), 5'd10, 5'd1, field), 32'h0);
      check_word(regs[10], exp, $sformatf("%s immediate 0x%03h", op.name(), field));
   endtask

   task automatic run_reg(input alu_op_e op, input word_t a, input word_t b);
      set_reg(5'd1, a);
      set_reg(5'd2, b);
      issue(enc_r(op, 5'd3, 5'd1, 5'd2), 32'h0);
      check_word(regs[3], alu_ref(op, a, b), $sformatf("%s register op", op.name()));
   endtask

   task automatic run_jal(input word_t pc, input logic [20:0] off);
      issue(enc_j(5'd6, off), pc);
      check_word(regs[6], pc + 32'd4, "JAL link");
      check_flag(o_pc_change, 1'b1, "JAL pc change");
      check_word(o_new_pc, pc + {{11{off[20]}}, off}, "JAL target");
   endtask

   task automatic run_jalr(input word_t pc, input word_t base, input logic [11:0] imm);
      word_t target;
      target = (base + sext12(imm)) & 32'hFFFF_FFFE;
      issue(enc_i(OPC_JALR, 3'b000, 5'd8, 5'd7, imm), pc);
      check_word(regs[8], pc + 32'd4, "JALR link");
      check_flag(o_pc_change, 1'b1, "JALR pc change");
      check_word(o_new_pc, target, "JALR target");
   endtask

   task automatic run_branch(input branch_e br, input word_t a, input word_t b,
                             input word_t pc, input logic [12:0] off);
      logic taken;
      taken = branch_ref(br, a, b);
      snap  = regs;
      issue(enc_b(br, 5'd11, 5'd12, off), pc);
      check_flag(o_pc_change, taken, $sformatf("%s taken", br.name()));
      if (taken) begin
         check_word(o_new_pc, pc + {{19{off[12]}}, off}, $sformatf("%s target", br.name()));
      end
      check_unchanged(br.name());
   endtask

   task automatic test_reset();
      check_flag(o_ack, 1'b0, "o_ack after reset");
      check_flag(o_pc_change, 1'b0, "o_pc_change after reset");
      check_word(o_new_pc, 32'h0, "o_new_pc after reset");
      for (int i = 0; i < NUM_REGS; i++) begin
         check_word(regs[i], 32'h0, $sformatf("x%0d after reset", i));
      end
      issue(enc_i(OPC_IMM, 3'b000, 5'd0, 5'd0, 12'd5), 32'h0);
      check_word(regs[0], 32'h0, "x0 after ADDI");
   endtask

   task automatic test_op_imm();
      logic [11:0] imms [3] = '{12'h7FF, 12'h800, 12'hF0F};
      word_t       srcs [2] = '{32'h1234_5FFF, 32'h8000_07FF};
      foreach (srcs[s]) begin
         set_reg(5'd1, srcs[s]);
         foreach (imms[j]) begin
            run_imm(ALU_ADD, srcs[s], imms[j]);
            run_imm(ALU_SLT, srcs[s], imms[j]);
            run_imm(ALU_SLTU, srcs[s], imms[j]);
            run_imm(ALU_XOR, srcs[s], imms[j]);
            run_imm(ALU_OR, srcs[s], imms[j]);
            run_imm(ALU_AND, srcs[s], imms[j]);
         end
         foreach (imms[j]) begin
            run_imm(ALU_SLL, srcs[s], imms[j]);
            run_imm(ALU_SRL, srcs[s], imms[j]);
            run_imm(ALU_SRA, srcs[s], imms[j]);
         end
      end
   endtask

   task automatic test_op_reg();
      for (int k = 0; k < 10; k++) begin
         run_reg(alu_op_e'(k[3:0]), $urandom, $urandom);
      end
      run_reg(ALU_ADD, 32'h7FFF_FFFF, 32'h0000_0001);
      run_reg(ALU_SUB, 32'h0000_0000, 32'h0000_0001);
      run_reg(ALU_SLT, 32'h8000_0000, 32'h7FFF_FFFF);
      run_reg(ALU_SLTU, 32'h8000_0000, 32'h7FFF_FFFF);
      // Shift amount comes from the low five bits only
      run_reg(ALU_SRA, 32'hF000_0000, 32'h0000_0024);
   endtask

   task automatic test_jumps();
      issue(enc_u(OPC_AUIPC, 5'd5, 20'h12345), 32'h0000_1000);
      check_word(regs[5], 32'h0000_1000 + 32'h1234_5000, "AUIPC result");
      check_flag(o_pc_change, 1'b0, "AUIPC pc change");
      run_jal(32'h0030_0000, 21'h10_0000);
      run_jal(32'h0000_0100, 21'h00_0804);
      set_reg(5'd7, 32'h0000_3001);
      run_jalr(32'h0000_0400, 32'h0000_3001, 12'h004);
      run_jalr(32'h0000_0400, 32'h0000_3001, 12'hFFD);
      run_jalr(32'h0000_0400, 32'h0000_3001, 12'h000);
   endtask

   task automatic test_branches();
      branch_e brs [6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
      word_t   as  [3] = '{32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0005};
      word_t   bs  [3] = '{32'h7FFF_FFFF, 32'h8000_0000, 32'h0000_0005};
      foreach (as[p]) begin
         set_reg(5'd11, as[p]);
         set_reg(5'd12, bs[p]);
         foreach (brs[k]) begin
            run_branch(brs[k], as[p], bs[p], 32'h0000_4000, 13'h1FE0);
         end
      end
   endtask

   task automatic test_handshake_nop();
      set_reg(5'd13, 32'h0000_0041);
      raise_req(enc_i(OPC_IMM, 3'b000, 5'd13, 5'd13, 12'd1), 32'h0);
      wait_ack();
      repeat (5) begin
         @(negedge clk);
         check_flag(o_ack, 1'b1, "o_ack while i_req held");
      end
      check_word(regs[13], 32'h0000_0042, "single write with i_req held");
      i_req = 1'b0;
      @(negedge clk);
      check_flag(o_ack, 1'b0, "o_ack after i_req low");
      // Leaves o_pc_change set ahead of the no-ops
      issue(enc_j(5'd0, 21'h00_0010), 32'h0000_0200);
      check_flag(o_pc_change, 1'b1, "JAL x0 pc change");
      snap = regs;
      issue(enc_i(OPC_LOAD, 3'b010, 5'd14, 5'd1, 12'h004), 32'h0000_0204);
      check_flag(o_pc_change, 1'b0, "LOAD pc change");
      check_unchanged("LOAD");
      issue({7'h00, 5'd2, 5'd1, 3'b010, 5'd14, OPC_STORE}, 32'h0000_0208);
      check_flag(o_pc_change, 1'b0, "STORE pc change");
      check_unchanged("STORE");
   endtask

   initial begin
      #(MAX_ISSUES * 40 * 100);
      $display("Watchdog expired: the DUT did not finish the tests in time");
      stop_with_failure();
   end

   initial begin
      clk     = 1'b0;
      i_rst_n = 1'b0;
      i_req   = 1'b0;
      i_inst  = '0;
      i_pc    = '0;
      void'($urandom(95));
      repeat (3) @(negedge clk);
      i_rst_n = 1'b1;
      test_reset();
      test_op_imm();
      test_op_reg();
      test_jumps();
      test_branches();
      test_handshake_nop();
      $display("** PASS **");
      $finish;
   end

endmodule

// ==== tb.f ====
source/rv_pkg.sv
source/rv_stage_if.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_exec_top.sv
dv/rv_exec_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module rv_exec_tb -f tb.f
	./obj_dir/Vrv_exec_tb | tee sim.log
	grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
